// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := issue_exe_tb
FILELIST   := files.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== files.f ====
+incdir+source
source/issue_pkg.sv
source/issue_buffer.sv
source/reg_file.sv
source/issue_select.sv
source/exe_stage.sv
source/issue_exe_top.sv
sim/issue_exe_sva.sv
sim/issue_exe_tb.sv

// ==== sim/issue_exe_sva.sv ====
`timescale 1ns/1ps

module issue_exe_sva import issue_pkg::*; (
    input logic          clk,
    input logic          rstn,
    input logic          i_dec_req,
    input logic          o_dec_ack,
    input logic          o_ret_req,
    input logic          i_ret_ack,
    input ret_bundle_t   o_ret_bundle,
    input issue_bundle_t i_issue,
    input logic          i_issue_valid
);

    // Offer held until the outside takes it
    ret_offer_stable_a: assert property (@(posedge clk) disable iff (!rstn)
        o_ret_req && !i_ret_ack |=> o_ret_req && $stable(o_ret_bundle))
        else $error("retire offer changed before ack");

    dec_ack_needs_req_a: assert property (@(posedge clk) disable iff (!rstn)
        $rose(o_dec_ack) |-> $past(i_dec_req))
        else $error("o_dec_ack rose without a request");

    // Only lane A has a shifter
    lane_b_no_shift_a: assert property (@(posedge clk) disable iff (!rstn)
        i_issue_valid && i_issue.lane_b.inst.valid
        |-> (i_issue.lane_b.inst.op != OP_SLL) && (i_issue.lane_b.inst.op != OP_SRL))
        else $error("shift issued to lane B");

endmodule

bind issue_exe_top issue_exe_sva sva_i (
    .clk           (clk),
    .rstn          (rstn),
    .i_dec_req     (i_dec_req),
    .o_dec_ack     (o_dec_ack),
    .o_ret_req     (o_ret_req),
    .i_ret_ack     (i_ret_ack),
    .o_ret_bundle  (o_ret_bundle),
    .i_issue       (issue),
    .i_issue_valid (issue_valid)
);

// ==== sim/issue_exe_tb.sv ====
`timescale 1ns/1ps
`include "issue_consts.svh"

module issue_exe_tb import issue_pkg::*; ();

    localparam int N_PAIRS  = 160;
    localparam int TIMEOUT  = 400;     // Cycles allowed for any one wait
    localparam int HOLD_AT  = 12;      // Bundle held under long back-pressure
    localparam int HOLD_LEN = 80;
    localparam int FLUSH_AT = 60;      // Bundle held while a flush goes by

    logic        clk;
    logic        rstn;
    logic        i_dec_req;
    logic        o_dec_ack;
    dec_pair_t   i_dec_pair;
    logic        i_flush;
    logic        o_ret_req;
    logic        i_ret_ack;
    ret_bundle_t o_ret_bundle;

    logic [31:0] rng_state = 32'd18106;
    tag_t        next_tag = '0;
    data_t       mregs [`NREG];        // Architectural state of the model
    dec_inst_t   sent_q [$];           // Sent but unretired instructions in program order
    logic        send_done = 1'b0;
    int          retired_cnt = 0;
    int          swap_cnt = 0;

    issue_exe_top dut_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_dec_req    (i_dec_req),
        .o_dec_ack    (o_dec_ack),
        .i_dec_pair   (i_dec_pair),
        .i_flush      (i_flush),
        .o_ret_req    (o_ret_req),
        .i_ret_ack    (i_ret_ack),
        .o_ret_bundle (o_ret_bundle)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_now();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic abort_run(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        fail_now();
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_rd(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
            fail_now();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////////////////////////////////////////

    // Two LCG steps per draw keeping the upper halves
    function automatic logic [31:0] next_rand();
        logic [31:0] hi;
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        hi        = rng_state;
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return {hi[31:16], rng_state[31:16]};
    endfunction

    function automatic logic is_shift_op(input alu_op_e op);
        return (op == OP_SLL) || (op == OP_SRL);
    endfunction

    // Only registers 0 to 5 so hazards come often
    function automatic dec_inst_t make_inst();
        dec_inst_t   d;
        logic [31:0] r;
        r = next_rand();
        d.valid = 1'b1;
        d.tag   = next_tag;
        next_tag++;
        if (r[2:0] < 3'd3) begin
            d.op = r[3] ? OP_SRL : OP_SLL;
        end else begin
            d.op = alu_op_e'({1'b0, r[6:4]});
        end
        d.src2_sel = r[7] ? SRC_IMM : SRC_REG;
        d.rs1      = reg_addr_t'(r[15:8] % 8'd6);
        d.rs2      = reg_addr_t'(r[23:16] % 8'd6);
        d.rd       = reg_addr_t'(r[31:24] % 8'd6);
        d.rd_we    = (r[27:25] != 3'd0);
        d.imm      = next_rand();
        return d;
    endfunction

    function automatic data_t model_exec(input dec_inst_t d);
        data_t a;
        data_t b;
        a = mregs[d.rs1];
        b = (d.src2_sel == SRC_IMM) ? d.imm : mregs[d.rs2];
        case (d.op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? data_t'(1) : data_t'(0);
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            default: return '0;
        endcase
    endfunction

    task automatic check_lane(input ret_lane_t l, input string lname);
        dec_inst_t exp;
        data_t     res;
        if (sent_q.size() == 0) begin
            abort_run({"retired ", lname, " with no instruction outstanding"});
        end
        exp = sent_q.pop_front();
        check_tag({"o_ret_bundle.", lname, ".tag"}, l.tag, exp.tag);
        check_rd({"o_ret_bundle.", lname, ".rd"}, l.rd, exp.rd);
        if (lname == "lane_b" && is_shift_op(exp.op)) begin
            abort_run("shift instruction retired in lane B");
        end
        check_flag({"o_ret_bundle.", lname, ".we"}, l.we, exp.rd_we);
        res = model_exec(exp);
        check_data({"o_ret_bundle.", lname, ".result"}, l.result, res);
        if (exp.rd_we && exp.rd != '0) begin
            mregs[exp.rd] = res;    // Register 0 stays zero
        end
        retired_cnt++;
    endtask

    // Older lane first as the swapped bit says
    task automatic check_bundle(input ret_bundle_t b);
        ret_lane_t older;
        ret_lane_t younger;
        older   = b.swapped ? b.lane_b : b.lane_a;
        younger = b.swapped ? b.lane_a : b.lane_b;
        if (!older.valid) begin
            abort_run("retired bundle has no valid older lane");
        end
        check_lane(older, b.swapped ? "lane_b" : "lane_a");
        if (younger.valid) begin
            check_lane(younger, b.swapped ? "lane_a" : "lane_b");
        end
        if (b.swapped) begin
            swap_cnt++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Handshake drivers
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_pairs(input int n_pairs);
        dec_pair_t p;
        int        wait_cyc;
        for (int k = 0; k < n_pairs; k++) begin
            p.slot0 = make_inst();
            if (next_rand() % 8 != 0) begin
                p.slot1 = make_inst();
            end else begin
                p.slot1 = '0;       // Lone older instruction
            end
            sent_q.push_back(p.slot0);
            if (p.slot1.valid) begin
                sent_q.push_back(p.slot1);
            end
            i_dec_pair = p;
            i_dec_req  = 1'b1;
            wait_cyc   = 0;
            do begin
                @(posedge clk);
                #2;
                wait_cyc++;
            end while (!o_dec_ack && wait_cyc < TIMEOUT);
            if (!o_dec_ack) begin
                abort_run("timed out waiting for o_dec_ack to rise");
            end
            i_dec_req = 1'b0;
            wait_cyc  = 0;
            do begin
                @(posedge clk);
                #2;
                wait_cyc++;
            end while (o_dec_ack && wait_cyc < TIMEOUT);
            if (o_dec_ack) begin
                abort_run("timed out waiting for o_dec_ack to fall");
            end
            repeat (int'(next_rand() % 4)) begin
                @(posedge clk);
                #2;
            end
        end
        send_done = 1'b1;
    endtask

    // Keeps ack low for some cycles while the offer must not move
    task automatic hold_ack(input ret_bundle_t held, input int cycles,
                            input logic watch_full, input logic flush_mid);
        logic prev_ack;
        prev_ack = o_dec_ack;
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            #1;
            if (!o_ret_req) begin
                abort_run("o_ret_req dropped while ack was withheld");
            end
            check_tag("o_ret_bundle.lane_a.tag", o_ret_bundle.lane_a.tag, held.lane_a.tag);
            check_tag("o_ret_bundle.lane_b.tag", o_ret_bundle.lane_b.tag, held.lane_b.tag);
            check_data("o_ret_bundle.lane_a.result", o_ret_bundle.lane_a.result,
                       held.lane_a.result);
            check_data("o_ret_bundle.lane_b.result", o_ret_bundle.lane_b.result,
                       held.lane_b.result);
            // Buffer is full well before the last 20 cycles
            if (watch_full && c >= cycles - 20 && o_dec_ack && !prev_ack) begin
                abort_run("o_dec_ack granted a pair while the buffer was full");
            end
            prev_ack = o_dec_ack;
            if (i_flush) begin
                sent_q.delete();    // Flush edge just passed so all unretired pairs are gone
            end
            #1;
            i_flush = flush_mid && (c == 2);
        end
    endtask

    task automatic retire_all();
        ret_bundle_t held;
        int          n_bundle;
        int          wait_cyc;
        int          delay;
        logic        finished;
        n_bundle = 0;
        finished = 1'b0;
        while (!finished) begin
            wait_cyc = 0;
            do begin
                @(posedge clk);
                #1;
                wait_cyc++;
            end while (!o_ret_req && !(send_done && sent_q.size() == 0)
                       && wait_cyc < TIMEOUT);
            if (o_ret_req) begin
                held = o_ret_bundle;
                check_bundle(held);
                n_bundle++;
                delay = int'(next_rand() % 4);
                #1;
                if (n_bundle == HOLD_AT) begin
                    hold_ack(held, HOLD_LEN, 1'b1, 1'b0);
                end else if (n_bundle == FLUSH_AT) begin
                    hold_ack(held, 8, 1'b0, 1'b1);
                end else begin
                    hold_ack(held, delay, 1'b0, 1'b0);
                end
                i_ret_ack = 1'b1;
                wait_cyc  = 0;
                do begin
                    @(posedge clk);
                    #1;
                    wait_cyc++;
                end while (o_ret_req && wait_cyc < TIMEOUT);
                if (o_ret_req) begin
                    abort_run("o_ret_req stayed high after ack");
                end
                #1;
                i_ret_ack = 1'b0;
            end else if (send_done && sent_q.size() == 0) begin
                finished = 1'b1;
            end else begin
                abort_run("timed out waiting for o_ret_req");
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rstn       = 1'b0;
        i_dec_req  = 1'b0;
        i_dec_pair = '0;
        i_flush    = 1'b0;
        i_ret_ack  = 1'b0;
        for (int i = 0; i < `NREG; i++) begin
            mregs[i] = '0;
        end
        repeat (4) @(posedge clk);
        #2;
        rstn = 1'b1;
        fork
            send_pairs(N_PAIRS);
            retire_all();
        join
        if (sent_q.size() != 0 || retired_cnt <= N_PAIRS) begin
            abort_run("run ended with too few instructions retired");
        end else if (swap_cnt == 0) begin
            abort_run("no bundle retired with its lanes swapped");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// ==== source/exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage import issue_pkg::*; (
    input  logic          clk,
    input  logic          rstn,
    input  issue_bundle_t i_issue,
    input  logic          i_issue_valid,
    output logic          o_ready,
    output pend_t         o_pend,
    output logic          o_ret_req,
    input  logic          i_ret_ack,
    output ret_bundle_t   o_ret_bundle,
    output logic          o_wen_a,
    output reg_addr_t     o_waddr_a,
    output data_t         o_wdata_a,
    output logic          o_wen_b,
    output reg_addr_t     o_waddr_b,
    output data_t         o_wdata_b,
    output logic          o_b_younger
);

    typedef enum logic [1:0] {IDLE, OFFER, WAIT_LOW} exe_state_e;

    exe_state_e  state;
    ret_bundle_t ret_q;
    ret_bundle_t ret_d;
    logic        load;
    logic        accept;

    // Shifter present only when has_shift is set
    function automatic data_t alu(input lane_inst_t l, input logic has_shift);
        data_t a;
        data_t b;
        a = l.rs1_val;
        b = (l.inst.src2_sel == SRC_IMM) ? l.inst.imm : l.rs2_val;
        case (l.inst.op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return data_t'($signed(a) < $signed(b));
            OP_SLL:  return has_shift ? (a << b[4:0]) : '0;
            OP_SRL:  return has_shift ? (a >> b[4:0]) : '0;
            default: return '0;
        endcase
    endfunction

    function automatic ret_lane_t retire(input lane_inst_t l, input logic has_shift);
        ret_lane_t r;
        r.valid  = l.inst.valid;
        r.tag    = l.inst.tag;
        r.rd     = l.inst.rd;
        r.we     = l.inst.valid && l.inst.rd_we;
        r.result = alu(l, has_shift);
        return r;
    endfunction

    assign ret_d.lane_a  = retire(i_issue.lane_a, 1'b1);
    assign ret_d.lane_b  = retire(i_issue.lane_b, 1'b0);
    assign ret_d.swapped = i_issue.swapped;

    ////////////////////////////////////////////////////////////////////////////
    // Retire handshake
    ////////////////////////////////////////////////////////////////////////////

    assign o_ready = (state == IDLE) || ((state == WAIT_LOW) && !i_ret_ack);
    assign load    = o_ready && i_issue_valid;
    assign accept  = (state == OFFER) && i_ret_ack;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
            ret_q <= '0;
        end else begin
            if (load) ret_q <= ret_d;
            case (state)
                IDLE:     if (load) state <= OFFER;
                OFFER:    if (i_ret_ack) state <= WAIT_LOW;
                WAIT_LOW: if (!i_ret_ack) state <= load ? OFFER : IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    assign o_ret_req    = (state == OFFER);
    assign o_ret_bundle = ret_q;

    // Results count as pending until the accept edge writes them
    assign o_pend.we = {o_ret_req && ret_q.lane_b.we, o_ret_req && ret_q.lane_a.we};
    assign o_pend.rd = {ret_q.lane_b.rd, ret_q.lane_a.rd};

    assign o_wen_a     = accept && ret_q.lane_a.we;
    assign o_waddr_a   = ret_q.lane_a.rd;
    assign o_wdata_a   = ret_q.lane_a.result;
    assign o_wen_b     = accept && ret_q.lane_b.we;
    assign o_waddr_b   = ret_q.lane_b.rd;
    assign o_wdata_b   = ret_q.lane_b.result;
    assign o_b_younger = !ret_q.swapped;

endmodule

// ==== source/issue_buffer.sv ====
`timescale 1ns/1ps
`include "issue_consts.svh"

module issue_buffer import issue_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      i_dec_req,
    output logic      o_dec_ack,
    input  dec_pair_t i_dec_pair,
    input  logic      i_flush,
    input  logic [1:0] i_pop,
    output dec_pair_t o_head,
    output logic      o_head_valid
);

    dec_pair_t mem [`BUF_DEPTH];
    buf_ptr_t  wr_ptr;
    buf_ptr_t  rd_ptr;
    buf_cnt_t  count;
    logic      full;
    logic      capture;
    logic      push;
    logic      pop_all;
    logic      pop_old;

    ////////////////////////////////////////////////////////////////////////////
    // Four-phase receiver
    ////////////////////////////////////////////////////////////////////////////

    assign full = (count == buf_cnt_t'(`BUF_DEPTH));

    // Fresh request only; a flush frees the room for a waiting one
    assign capture = i_dec_req && !o_dec_ack && (!full || i_flush);
    assign push    = capture && !i_flush;      // Flushed pair is acked but dropped

    assign pop_all = (i_pop == 2'd2) && !i_flush;
    assign pop_old = (i_pop == 2'd1) && !i_flush;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_dec_ack <= 1'b0;
        end else if (capture) begin
            o_dec_ack <= 1'b1;
        end else if (!i_dec_req) begin
            o_dec_ack <= 1'b0;                 // Source dropped req, close
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Circular pair queue
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_all) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + buf_cnt_t'(push) - buf_cnt_t'(pop_all);
        end
    end

    // Push and partial pop never share an entry, full blocks the push
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_dec_pair;
        end
        if (pop_old) begin
            mem[rd_ptr].slot0       <= mem[rd_ptr].slot1;   // Younger moves up
            mem[rd_ptr].slot1.valid <= 1'b0;
        end
    end

    assign o_head       = mem[rd_ptr];
    assign o_head_valid = (count != '0);

endmodule

// ==== source/issue_consts.svh ====
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

`define XLEN      32    // Data word
`define NREG      32    // Architectural registers
`define REG_AW    5     // Register address bits
`define TAG_W     8     // Program order tag

////////////////////////////////////////////////////////////////////////////
// Issue buffer geometry
////////////////////////////////////////////////////////////////////////////

// Pair entries, kept a power of two so the pointers wrap on their own
`define BUF_DEPTH 4
`define BUF_AW    2     // Pointer bits
`define BUF_CW    3     // Count bits, holds 0 to BUF_DEPTH

`endif

// ==== source/issue_exe_top.sv ====
`timescale 1ns/1ps

module issue_exe_top import issue_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_dec_req,
    output logic        o_dec_ack,
    input  dec_pair_t   i_dec_pair,
    input  logic        i_flush,
    output logic        o_ret_req,
    input  logic        i_ret_ack,
    output ret_bundle_t o_ret_bundle
);

    dec_pair_t       head;
    logic            head_valid;
    logic [1:0]      pop;
    reg_addr_t [3:0] raddr;
    data_t [3:0]     rdata;
    pend_t           exe_pend;
    logic            exe_ready;
    issue_bundle_t   issue;
    logic            issue_valid;
    logic            wen_a;
    reg_addr_t       waddr_a;
    data_t           wdata_a;
    logic            wen_b;
    reg_addr_t       waddr_b;
    data_t           wdata_b;
    logic            b_younger;

    issue_buffer buf_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_dec_req    (i_dec_req),
        .o_dec_ack    (o_dec_ack),
        .i_dec_pair   (i_dec_pair),
        .i_flush      (i_flush),
        .i_pop        (pop),
        .o_head       (head),
        .o_head_valid (head_valid)
    );

    issue_select sel_i (
        .clk           (clk),
        .rstn          (rstn),
        .i_head        (head),
        .i_head_valid  (head_valid),
        .o_pop         (pop),
        .o_raddr       (raddr),
        .i_rdata       (rdata),
        .i_exe_pend    (exe_pend),
        .i_exe_ready   (exe_ready),
        .i_flush       (i_flush),
        .o_issue       (issue),
        .o_issue_valid (issue_valid)
    );

    reg_file rf_i (
        .clk         (clk),
        .rstn        (rstn),
        .i_raddr     (raddr),
        .o_rdata     (rdata),
        .i_wen_a     (wen_a),
        .i_waddr_a   (waddr_a),
        .i_wdata_a   (wdata_a),
        .i_wen_b     (wen_b),
        .i_waddr_b   (waddr_b),
        .i_wdata_b   (wdata_b),
        .i_b_younger (b_younger)
    );

    exe_stage exe_i (
        .clk           (clk),
        .rstn          (rstn),
        .i_issue       (issue),
        .i_issue_valid (issue_valid),
        .o_ready       (exe_ready),
        .o_pend        (exe_pend),
        .o_ret_req     (o_ret_req),
        .i_ret_ack     (i_ret_ack),
        .o_ret_bundle  (o_ret_bundle),
        .o_wen_a       (wen_a),
        .o_waddr_a     (waddr_a),
        .o_wdata_a     (wdata_a),
        .o_wen_b       (wen_b),
        .o_waddr_b     (waddr_b),
        .o_wdata_b     (wdata_b),
        .o_b_younger   (b_younger)
    );

endmodule

// ==== source/issue_pkg.sv ====
`include "issue_consts.svh"

package issue_pkg;

    typedef logic [`XLEN-1:0]   data_t;
    typedef logic [`REG_AW-1:0] reg_addr_t;
    typedef logic [`TAG_W-1:0]  tag_t;
    typedef logic [`BUF_AW-1:0] buf_ptr_t;
    typedef logic [`BUF_CW-1:0] buf_cnt_t;

    // SLL and SRL form the shift class, lane A only
    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLL, OP_SRL
    } alu_op_e;

    typedef enum logic {SRC_REG, SRC_IMM} src_sel_e;    // Second operand source

    typedef struct packed {
        logic      valid;
        tag_t      tag;
        alu_op_e   op;
        src_sel_e  src2_sel;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      rd_we;
        data_t     imm;
    } dec_inst_t;

    typedef struct packed {
        dec_inst_t slot1;   // Younger
        dec_inst_t slot0;   // Older
    } dec_pair_t;

    typedef struct packed {
        dec_inst_t inst;
        data_t     rs1_val;
        data_t     rs2_val;
    } lane_inst_t;

    typedef struct packed {
        lane_inst_t lane_a;
        lane_inst_t lane_b;
        logic       swapped;    // Lane B holds the older one
    } issue_bundle_t;

    typedef struct packed {
        logic      valid;
        tag_t      tag;
        reg_addr_t rd;
        logic      we;
        data_t     result;
    } ret_lane_t;

    typedef struct packed {
        ret_lane_t lane_a;
        ret_lane_t lane_b;
        logic      swapped;
    } ret_bundle_t;

    // Destinations still to be written by one stage
    typedef struct packed {
        logic [1:0]      we;
        reg_addr_t [1:0] rd;
    } pend_t;

endpackage

// ==== source/issue_select.sv ====
`timescale 1ns/1ps

module issue_select import issue_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  dec_pair_t       i_head,
    input  logic            i_head_valid,
    output logic [1:0]      o_pop,
    output reg_addr_t [3:0] o_raddr,
    input  data_t [3:0]     i_rdata,
    input  pend_t           i_exe_pend,
    input  logic            i_exe_ready,
    input  logic            i_flush,
    output issue_bundle_t   o_issue,
    output logic            o_issue_valid
);

    issue_bundle_t issue_q;
    issue_bundle_t issue_d;
    logic          issue_vld_q;
    pend_t         own_pend;
    pend_t         old_pend;
    dec_inst_t     old_i;
    dec_inst_t     yng_i;
    lane_inst_t    lane_old;
    lane_inst_t    lane_yng;
    logic          old_ok;
    logic          yng_ok;
    logic          swap;
    logic          can_load;
    logic          fire;

    function automatic logic is_shift(input alu_op_e op);
        return (op == OP_SLL) || (op == OP_SRL);
    endfunction

    function automatic logic pend_hit(input pend_t p, input reg_addr_t r);
        return (r != '0) && ((p.we[0] && (p.rd[0] == r)) || (p.we[1] && (p.rd[1] == r)));
    endfunction

    // RAW check of one instruction against one stage
    function automatic logic blocked(input dec_inst_t d, input pend_t p);
        return pend_hit(p, d.rs1) || ((d.src2_sel == SRC_REG) && pend_hit(p, d.rs2));
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Hazard, split and lane swap
    ////////////////////////////////////////////////////////////////////////////

    assign old_i = i_head.slot0;
    assign yng_i = i_head.slot1;

    // Own destinations, still in the issue register
    always_comb begin
        own_pend.we[0] = issue_vld_q && issue_q.lane_a.inst.valid && issue_q.lane_a.inst.rd_we;
        own_pend.we[1] = issue_vld_q && issue_q.lane_b.inst.valid && issue_q.lane_b.inst.rd_we;
        own_pend.rd[0] = issue_q.lane_a.inst.rd;
        own_pend.rd[1] = issue_q.lane_b.inst.rd;
    end

    assign old_pend.we = {1'b0, old_i.rd_we};   // Older slot seen as a producer
    assign old_pend.rd = {old_i.rd, old_i.rd};

    assign old_ok = i_head_valid && old_i.valid
                 && !blocked(old_i, own_pend) && !blocked(old_i, i_exe_pend);
    assign yng_ok = old_ok && yng_i.valid
                 && !blocked(yng_i, own_pend) && !blocked(yng_i, i_exe_pend)
                 && !blocked(yng_i, old_pend)
                 && !(is_shift(old_i.op) && is_shift(yng_i.op));

    assign swap     = yng_ok && is_shift(yng_i.op) && !is_shift(old_i.op);
    assign can_load = !issue_vld_q || i_exe_ready;   // Free or moving on
    assign fire     = can_load && old_ok && !i_flush;

    always_comb begin
        if (fire) begin
            o_pop = (yng_i.valid && !yng_ok) ? 2'd1 : 2'd2;    // Split leaves the younger
        end else if (!i_flush && i_head_valid && !old_i.valid) begin
            o_pop = 2'd2;                                      // Empty entry, discard
        end else begin
            o_pop = 2'd0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Operand read and lane assembly
    ////////////////////////////////////////////////////////////////////////////

    assign o_raddr = {yng_i.rs2, yng_i.rs1, old_i.rs2, old_i.rs1};

    always_comb begin
        lane_old.inst       = old_i;
        lane_old.inst.valid = fire;
        lane_old.rs1_val    = i_rdata[0];
        lane_old.rs2_val    = i_rdata[1];
        lane_yng.inst       = yng_i;
        lane_yng.inst.valid = fire && yng_ok;
        lane_yng.rs1_val    = i_rdata[2];
        lane_yng.rs2_val    = i_rdata[3];
        issue_d.lane_a      = swap ? lane_yng : lane_old;
        issue_d.lane_b      = swap ? lane_old : lane_yng;
        issue_d.swapped     = swap;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            issue_vld_q <= 1'b0;
            issue_q     <= '0;
        end else if (i_flush) begin
            issue_vld_q               <= 1'b0;
            issue_q.lane_a.inst.valid <= 1'b0;
            issue_q.lane_b.inst.valid <= 1'b0;
        end else if (can_load) begin
            issue_vld_q <= fire;
            issue_q     <= issue_d;
        end
    end

    assign o_issue       = issue_q;
    assign o_issue_valid = issue_vld_q && !i_flush;    // Nothing moves on a flush

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`include "issue_consts.svh"

module reg_file import issue_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  reg_addr_t [3:0] i_raddr,
    output data_t [3:0]     o_rdata,
    input  logic            i_wen_a,
    input  reg_addr_t       i_waddr_a,
    input  data_t           i_wdata_a,
    input  logic            i_wen_b,
    input  reg_addr_t       i_waddr_b,
    input  data_t           i_wdata_b,
    input  logic            i_b_younger
);

    data_t regs [1:`NREG-1];    // No storage behind register 0
    logic  wr_a;
    logic  wr_b;

    assign wr_a = i_wen_a && (i_waddr_a != '0);
    assign wr_b = i_wen_b && (i_waddr_b != '0);

    // Younger write issued last, so it wins on a shared address
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 1; i < `NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (i_b_younger) begin
            if (wr_a) regs[i_waddr_a] <= i_wdata_a;
            if (wr_b) regs[i_waddr_b] <= i_wdata_b;
        end else begin
            if (wr_b) regs[i_waddr_b] <= i_wdata_b;
            if (wr_a) regs[i_waddr_a] <= i_wdata_a;
        end
    end

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            o_rdata[p] = (i_raddr[p] == '0) ? '0 : regs[i_raddr[p]];
        end
    end

endmodule
